/* design/error_tracker_config.svh */
`ifndef ERROR_TRACKER_CONFIG_SVH
`define ERROR_TRACKER_CONFIG_SVH

// Lanes in one quarter of the receiver
`define ET_WIDTH 8

// All lanes of the receiver
`define ET_LANES (4 * `ET_WIDTH)

// Signed equalizer error per lane
`define ET_ERR_BITS 8

// Decoded PAM4 symbol width
`define ET_SYM_BITS 2

// Raw symbol levels are signed and carry one more bit than the decoded code
`define ET_RAW_SYM_BITS (`ET_SYM_BITS + 1)

// Sliding detector flags per lane
`define ET_FLAG_BITS 4

// Capture memory geometry
`define ET_ROW_BITS 64
`define ET_ADDR_BITS 6

// One capture fills this many consecutive rows
`define ET_FRAMES 8

// Debug readout word and the number of words per row
`define ET_CHUNK_BITS 32
`define ET_CHUNKS (`ET_ROW_BITS / `ET_CHUNK_BITS)

`endif

/* design/error_tracker_pkg.sv */
`include "error_tracker_config.svh"

package error_tracker_pkg;

	// READY waits for a trigger, STORE writes the frames, DONE hands the
	// memory to the debug port
	typedef enum logic [1:0] {
		READY = 2'd0,
		STORE = 2'd1,
		DONE  = 2'd2
	} tracker_state_t;

	// One equalizer error sample
	typedef logic signed [`ET_ERR_BITS-1:0] lane_err_t;

	// One row of the capture memory
	// The packer fills error frames lane by lane, the readout side only sees
	// the row as a pair of debug words
	typedef union packed {
		lane_err_t [`ET_WIDTH-1:0] lanes;
		logic [`ET_CHUNKS-1:0][`ET_CHUNK_BITS-1:0] chunks;
	} frame_row_u;

endpackage

/* design/frame_packer.sv */
`include "error_tracker_config.svh"

module frame_packer
	import error_tracker_pkg::*;
(
	input  logic clk,
	input  logic rstb,
	input  logic latch,
	input  logic [`ET_LANES*`ET_ERR_BITS-1:0] errors,
	input  logic [`ET_LANES*`ET_SYM_BITS-1:0] prbs_flags,
	input  logic [`ET_LANES*`ET_RAW_SYM_BITS-1:0] symbols,
	input  logic [`ET_LANES*`ET_FLAG_BITS-1:0] sd_flags,
	output frame_row_u frames [`ET_FRAMES-1:0]
);

	localparam int quarters = `ET_LANES / `ET_WIDTH;

	frame_row_u next_frames [`ET_FRAMES-1:0];
	logic [`ET_ROW_BITS-1:0] sym_row;

	// PAM4 level to two-bit code
	// Levels that are not legal PAM4 values collapse to the -3 code
	function automatic logic [`ET_SYM_BITS-1:0] pam4_decode(
		input logic signed [`ET_RAW_SYM_BITS-1:0] level
	);
		logic [`ET_SYM_BITS-1:0] code;
		case (level)
			3'sd3: code = 2'b10;
			3'sd1: code = 2'b11;
			-3'sd1: code = 2'b01;
			-3'sd3: code = 2'b00;
			default: code = 2'b00;
		endcase
		return code;
	endfunction

	// Lane i of the symbol stream lands at bits 2i+1:2i of the symbol frame
	always_comb begin
		for (int i = 0; i < `ET_LANES; i++) begin
			sym_row[i*`ET_SYM_BITS +: `ET_SYM_BITS] =
				pam4_decode(symbols[i*`ET_RAW_SYM_BITS +: `ET_RAW_SYM_BITS]);
		end
	end

	always_comb begin
		// Frames 0 to 3 carry one quarter of the error lanes each, lowest lane at bit 0
		for (int q = 0; q < quarters; q++) begin
			for (int j = 0; j < `ET_WIDTH; j++) begin
				next_frames[q].lanes[j] =
					errors[(q*`ET_WIDTH + j)*`ET_ERR_BITS +: `ET_ERR_BITS];
			end
		end

		next_frames[4] = prbs_flags;
		next_frames[5] = sym_row;

		// Sliding detector lanes 0 to 15 go in frame 6, the upper half in frame 7
		next_frames[6] = sd_flags[`ET_ROW_BITS-1:0];
		next_frames[7] = sd_flags[2*`ET_ROW_BITS-1:`ET_ROW_BITS];
	end

	// The snapshot follows the inputs while latch is high and freezes
	// once the controller starts writing it out
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int k = 0; k < `ET_FRAMES; k++) begin
				frames[k] <= '0;
			end
		end else if (latch) begin
			for (int k = 0; k < `ET_FRAMES; k++) begin
				frames[k] <= next_frames[k];
			end
		end
	end

endmodule

/* design/tracker_ctrl.sv */
`include "error_tracker_config.svh"

module tracker_ctrl
	import error_tracker_pkg::*;
(
	input  logic clk,
	input  logic rstb,
	input  logic trigger,
	input  logic dbg_read,
	input  logic dbg_rearm,
	input  logic [`ET_ADDR_BITS-1:0] dbg_addr,
	input  frame_row_u frames [`ET_FRAMES-1:0],
	output logic latch,
	output logic web,
	output logic [`ET_ADDR_BITS-1:0] addr,
	output frame_row_u wdata,
	output logic [`ET_ADDR_BITS-1:0] stored_frames,
	output logic dbg_done
);

	localparam int cnt_bits = $clog2(`ET_FRAMES);
	localparam logic [cnt_bits-1:0] last_frame = cnt_bits'(`ET_FRAMES - 1);
	localparam logic [`ET_ADDR_BITS-1:0] max_addr = '1;

	tracker_state_t state;
	logic [cnt_bits-1:0] frame_cnt;
	logic [`ET_ADDR_BITS-1:0] write_addr;
	logic last;
	logic at_end;
	logic chain;

	assign last = (frame_cnt == last_frame);
	assign at_end = (write_addr == max_addr);

	// A trigger on the last frame starts the next capture right behind this one
	assign chain = (state == STORE) && last && trigger && !at_end;

	assign latch = (state == READY) || chain;

	// The debug port owns the address only once capture is over
	assign addr = (state == DONE) ? dbg_addr : write_addr;
	assign wdata = frames[frame_cnt];

	assign stored_frames = write_addr;
	assign dbg_done = (state == DONE);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= READY;
			frame_cnt <= '0;
			write_addr <= '0;
			web <= 1'b1;
		end else begin
			case (state)
				READY: begin
					// The trigger takes priority over a read request on the same edge
					if (trigger) begin
						web <= 1'b0;
						frame_cnt <= '0;
						state <= STORE;
					end else if (dbg_read) begin
						state <= DONE;
					end
				end
				STORE: begin
					if (at_end) begin
						// Last row of the memory was just written, the address parks at the top
						web <= 1'b1;
						frame_cnt <= '0;
						state <= DONE;
					end else begin
						write_addr <= write_addr + 1'b1;
						frame_cnt <= last ? '0 : frame_cnt + 1'b1;
						if (last && !trigger) begin
							web <= 1'b1;
							state <= dbg_read ? DONE : READY;
						end
					end
				end
				DONE: begin
					web <= 1'b1;
					if (dbg_rearm) begin
						write_addr <= '0;
						frame_cnt <= '0;
						state <= READY;
					end
				end
				default: begin
					web <= 1'b1;
					frame_cnt <= '0;
					state <= READY;
				end
			endcase
		end
	end

endmodule

/* design/capture_sram.sv */
`include "error_tracker_config.svh"

module capture_sram
	import error_tracker_pkg::*;
(
	input  logic clk,
	input  logic web,
	input  logic [`ET_ADDR_BITS-1:0] addr,
	input  frame_row_u wdata,
	output frame_row_u rdata
);

	localparam int depth = 2 ** `ET_ADDR_BITS;

	frame_row_u mem [depth-1:0];

	// Single port, so a write cycle leaves the read data as it was
	always_ff @(posedge clk) begin
		if (!web) begin
			mem[addr] <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

/* design/readout_slicer.sv */
`include "error_tracker_config.svh"

module readout_slicer
	import error_tracker_pkg::*;
(
	input  logic clk,
	input  logic rstb,
	input  frame_row_u rdata,
	input  logic dbg_chunk,
	output logic [`ET_CHUNK_BITS-1:0] dbg_data
);

	logic chunk_q;

	// The memory takes one edge to return the row, so the chunk index is
	// held back by one edge to meet it
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			chunk_q <= 1'b0;
			dbg_data <= '0;
		end else begin
			chunk_q <= dbg_chunk;
			dbg_data <= rdata.chunks[chunk_q];
		end
	end

endmodule

/* design/error_tracker_top.sv */
`include "error_tracker_config.svh"

module error_tracker_top
	import error_tracker_pkg::*;
(
	input  logic clk,
	input  logic rstb,

	// Receiver side
	input  logic trigger,
	input  logic [`ET_LANES*`ET_ERR_BITS-1:0] errors,
	input  logic [`ET_LANES*`ET_SYM_BITS-1:0] prbs_flags,
	input  logic [`ET_LANES*`ET_RAW_SYM_BITS-1:0] symbols,
	input  logic [`ET_LANES*`ET_FLAG_BITS-1:0] sd_flags,

	// Debug port
	input  logic [`ET_ADDR_BITS-1:0] dbg_addr,
	input  logic dbg_chunk,
	input  logic dbg_read,
	input  logic dbg_rearm,
	output logic [`ET_CHUNK_BITS-1:0] dbg_data,
	output logic [`ET_ADDR_BITS-1:0] stored_frames,
	output logic dbg_done
);

	frame_row_u frames [`ET_FRAMES-1:0];
	frame_row_u wdata;
	frame_row_u rdata;
	logic latch;
	logic web;
	logic [`ET_ADDR_BITS-1:0] addr;

	frame_packer u_packer (
		.clk        (clk),
		.rstb       (rstb),
		.latch      (latch),
		.errors     (errors),
		.prbs_flags (prbs_flags),
		.symbols    (symbols),
		.sd_flags   (sd_flags),
		.frames     (frames)
	);

	tracker_ctrl u_ctrl (
		.clk           (clk),
		.rstb          (rstb),
		.trigger       (trigger),
		.dbg_read      (dbg_read),
		.dbg_rearm     (dbg_rearm),
		.dbg_addr      (dbg_addr),
		.frames        (frames),
		.latch         (latch),
		.web           (web),
		.addr          (addr),
		.wdata         (wdata),
		.stored_frames (stored_frames),
		.dbg_done      (dbg_done)
	);

	capture_sram u_sram (
		.clk   (clk),
		.web   (web),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata)
	);

	readout_slicer u_slicer (
		.clk       (clk),
		.rstb      (rstb),
		.rdata     (rdata),
		.dbg_chunk (dbg_chunk),
		.dbg_data  (dbg_data)
	);

endmodule

/* dv/error_tracker_chk.sv */
`include "error_tracker_config.svh"

module error_tracker_chk
	import error_tracker_pkg::*;
(
	input logic clk,
	input logic rstb,
	input tracker_state_t state,
	input logic web,
	input frame_row_u wdata,
	input logic dbg_rearm,
	input logic [`ET_ADDR_BITS-1:0] write_addr
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// The debug port owns the memory in DONE, so no write may happen there
	no_write_in_done: assert property (@(posedge clk) disable iff (!rstb)
		(state == DONE) |-> web)
		else begin
			fail_count++;
			$error("memory write enabled while the tracker is in DONE");
		end

	// Only a re-arm in DONE moves the write address back
	addr_never_drops: assert property (@(posedge clk) disable iff (!rstb)
		!(state == DONE && dbg_rearm) |=> (write_addr >= $past(write_addr)))
		else begin
			fail_count++;
			$error("write address decreased without a re-arm");
		end

	// The packer must not relatch while the debug port reads the memory
	snapshot_held_in_done: assert property (@(posedge clk) disable iff (!rstb)
		(state == DONE) |=> $stable(wdata))
		else begin
			fail_count++;
			$error("packer snapshot changed while the tracker is in DONE");
		end

endmodule

bind tracker_ctrl error_tracker_chk u_chk (
	.clk        (clk),
	.rstb       (rstb),
	.state      (state),
	.web        (web),
	.wdata      (wdata),
	.dbg_rearm  (dbg_rearm),
	.write_addr (write_addr)
);

/* dv/error_tracker_monitor.sv */
`include "error_tracker_config.svh"

module error_tracker_monitor (
	input  logic clk,
	input  logic rstb,
	input  logic [`ET_ADDR_BITS-1:0] dbg_addr,
	input  logic dbg_chunk,
	input  logic [`ET_CHUNK_BITS-1:0] dbg_data,
	input  logic [`ET_ADDR_BITS-1:0] stored_frames,
	input  logic exp_valid,
	input  logic [`ET_CHUNK_BITS-1:0] exp_chunk,
	input  logic check_stored,
	input  logic [`ET_ADDR_BITS-1:0] exp_stored,
	output int mismatch_count
);

	timeunit 1ns;
	timeprecision 1ps;

	// Two stages, matching the memory read and the slicer register
	logic [1:0] pipe_valid;
	logic [`ET_CHUNK_BITS-1:0] pipe_data [2];
	logic [`ET_ADDR_BITS-1:0] pipe_addr [2];
	logic pipe_sel [2];

	always @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[0], exp_valid};
			pipe_data[0] <= exp_chunk;
			pipe_data[1] <= pipe_data[0];
			pipe_addr[0] <= dbg_addr;
			pipe_addr[1] <= pipe_addr[0];
			pipe_sel[0] <= dbg_chunk;
			pipe_sel[1] <= pipe_sel[0];
		end
	end

	initial begin
		mismatch_count = 0;
	end

	// Outputs settle on the rising edge, so compare half a cycle later
	always @(negedge clk) begin
		if (pipe_valid[1] && dbg_data !== pipe_data[1]) begin
			$display("MISMATCH at %0t: dbg_data (row %0d chunk %0d) got %08h expected %08h",
				$time, pipe_addr[1], pipe_sel[1], dbg_data, pipe_data[1]);
			mismatch_count++;
		end
		if (check_stored && stored_frames !== exp_stored) begin
			$display("MISMATCH at %0t: stored_frames got %0d expected %0d",
				$time, stored_frames, exp_stored);
			mismatch_count++;
		end
	end

endmodule

/* dv/error_tracker_tb.sv */
`include "error_tracker_config.svh"

module error_tracker_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int err_w = `ET_LANES * `ET_ERR_BITS;
	localparam int prbs_w = `ET_LANES * `ET_SYM_BITS;
	localparam int sym_w = `ET_LANES * `ET_RAW_SYM_BITS;
	localparam int sd_w = `ET_LANES * `ET_FLAG_BITS;
	localparam int rows = 2 ** `ET_ADDR_BITS;
	localparam int done_timeout = 20;

	logic clk;
	logic rstb;
	logic trigger;
	logic [err_w-1:0] errors;
	logic [prbs_w-1:0] prbs_flags;
	logic [sym_w-1:0] symbols;
	logic [sd_w-1:0] sd_flags;
	logic [`ET_ADDR_BITS-1:0] dbg_addr;
	logic dbg_chunk;
	logic dbg_read;
	logic dbg_rearm;
	logic [`ET_CHUNK_BITS-1:0] dbg_data;
	logic [`ET_ADDR_BITS-1:0] stored_frames;
	logic dbg_done;

	// Expectations handed to the monitor
	logic exp_valid;
	logic [`ET_CHUNK_BITS-1:0] exp_chunk;
	logic check_stored;
	logic [`ET_ADDR_BITS-1:0] exp_stored;

	logic [`ET_ROW_BITS-1:0] model_mem [rows];
	int exp_base;
	int seed = 32'hadab0039;
	int mismatch_count;
	int timeout_count;
	int assert_fails;

	error_tracker_top uut (
		.clk           (clk),
		.rstb          (rstb),
		.trigger       (trigger),
		.errors        (errors),
		.prbs_flags    (prbs_flags),
		.symbols       (symbols),
		.sd_flags      (sd_flags),
		.dbg_addr      (dbg_addr),
		.dbg_chunk     (dbg_chunk),
		.dbg_read      (dbg_read),
		.dbg_rearm     (dbg_rearm),
		.dbg_data      (dbg_data),
		.stored_frames (stored_frames),
		.dbg_done      (dbg_done)
	);

	error_tracker_monitor mon (
		.clk            (clk),
		.rstb           (rstb),
		.dbg_addr       (dbg_addr),
		.dbg_chunk      (dbg_chunk),
		.dbg_data       (dbg_data),
		.stored_frames  (stored_frames),
		.exp_valid      (exp_valid),
		.exp_chunk      (exp_chunk),
		.check_stored   (check_stored),
		.exp_stored     (exp_stored),
		.mismatch_count (mismatch_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Expected row k of a capture, built from the snapshot on the trigger edge
	function automatic logic [`ET_ROW_BITS-1:0] pack_frame(
		input logic [err_w-1:0] err,
		input logic [prbs_w-1:0] prbs,
		input logic [sym_w-1:0] sym,
		input logic [sd_w-1:0] sd,
		input int k
	);
		logic [`ET_ROW_BITS-1:0] row;
		int lvl;
		row = '0;
		if (k < 4) begin
			for (int j = 0; j < `ET_WIDTH; j++) begin
				row[j*`ET_ERR_BITS +: `ET_ERR_BITS] =
					err[(k*`ET_WIDTH + j)*`ET_ERR_BITS +: `ET_ERR_BITS];
			end
		end else if (k == 4) begin
			row = prbs;
		end else if (k == 5) begin
			for (int i = 0; i < `ET_LANES; i++) begin
				lvl = $signed(sym[i*`ET_RAW_SYM_BITS +: `ET_RAW_SYM_BITS]);
				if (lvl == 3)
					row[i*2 +: 2] = 2'b10;
				else if (lvl == 1)
					row[i*2 +: 2] = 2'b11;
				else if (lvl == -1)
					row[i*2 +: 2] = 2'b01;
				else
					row[i*2 +: 2] = 2'b00;
			end
		end else if (k == 6) begin
			row = sd[`ET_ROW_BITS-1:0];
		end else begin
			row = sd[2*`ET_ROW_BITS-1:`ET_ROW_BITS];
		end
		return row;
	endfunction

	// Patterns 0 to 3 rotate the legal PAM4 levels across lanes, pattern 4 uses illegal ones
	function automatic logic [2:0] lane_level(input int pattern, input int lane);
		logic [2:0] legal [4];
		logic [2:0] illegal [4];
		legal = '{3'b011, 3'b001, 3'b111, 3'b101};
		illegal = '{3'b000, 3'b010, 3'b110, 3'b100};
		if (pattern < 4)
			return legal[(pattern + lane) % 4];
		return illegal[lane % 4];
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic drive_receiver(input int pattern);
		for (int w = 0; w < err_w / 32; w++) begin
			errors[w*32 +: 32] = $random(seed);
		end
		prbs_flags = {$random(seed), $random(seed)};
		sd_flags = {$random(seed), $random(seed), $random(seed), $random(seed)};
		if (pattern < 0) begin
			symbols = {$random(seed), $random(seed), $random(seed)};
		end else begin
			for (int i = 0; i < `ET_LANES; i++) begin
				symbols[i*`ET_RAW_SYM_BITS +: `ET_RAW_SYM_BITS] = lane_level(pattern, i);
			end
		end
	endtask

	// Runs count chained captures; hold keeps trigger high on every edge
	task automatic run_captures(input int count, input bit sweep, input bit hold,
		input bit read_end);
		int rnd;
		for (int c = 0; c < count; c++) begin
			drive_receiver(sweep ? c : -1);
			trigger = 1'b1;
			for (int r = 0; r < `ET_FRAMES; r++) begin
				model_mem[exp_base + r] = pack_frame(errors, prbs_flags, symbols, sd_flags, r);
			end
			exp_base += `ET_FRAMES;
			// Triggers on the frames before the last must be ignored
			for (int i = 1; i < `ET_FRAMES; i++) begin
				next_cycle();
				drive_receiver(-1);
				rnd = $random(seed);
				trigger = hold || rnd[0];
			end
			next_cycle();
		end
		drive_receiver(-1);
		trigger = hold;
		dbg_read = read_end;
		next_cycle();
		trigger = 1'b0;
		dbg_read = 1'b0;
	endtask

	task automatic wait_for_done(input string what);
		int cycles;
		cycles = 0;
		while (!dbg_done && cycles < done_timeout) begin
			next_cycle();
			cycles++;
		end
		if (!dbg_done) begin
			$display("Timeout at %0t: dbg_done never rose %s", $time, what);
			timeout_count++;
		end
	endtask

	task automatic check_stored_frames(input int expected);
		check_stored = 1'b1;
		exp_stored = `ET_ADDR_BITS'(expected);
		next_cycle();
		check_stored = 1'b0;
	endtask

	task automatic read_rows(input int first, input int last);
		for (int r = first; r <= last; r++) begin
			for (int c = 0; c < `ET_CHUNKS; c++) begin
				dbg_addr = `ET_ADDR_BITS'(r);
				dbg_chunk = c[0];
				exp_valid = 1'b1;
				exp_chunk = model_mem[r][c*`ET_CHUNK_BITS +: `ET_CHUNK_BITS];
				next_cycle();
			end
		end
		exp_valid = 1'b0;
		// Let the last read drain through the memory and the slicer
		repeat (3) next_cycle();
	endtask

	task automatic rearm();
		dbg_rearm = 1'b1;
		next_cycle();
		dbg_rearm = 1'b0;
		exp_base = 0;
	endtask

	initial begin
		rstb = 1'b0;
		trigger = 1'b0;
		errors = '0;
		prbs_flags = '0;
		symbols = '0;
		sd_flags = '0;
		dbg_addr = '0;
		dbg_chunk = 1'b0;
		dbg_read = 1'b0;
		dbg_rearm = 1'b0;
		exp_valid = 1'b0;
		exp_chunk = '0;
		check_stored = 1'b0;
		exp_stored = '0;
		exp_base = 0;
		timeout_count = 0;
		repeat (2) @(posedge clk);
		#5;
		rstb = 1'b1;
		next_cycle();

		// One capture, then the read request on its last frame
		run_captures(1, 1'b0, 1'b0, 1'b1);
		wait_for_done("after a single capture");
		check_stored_frames(8);
		read_rows(0, 7);

		// Five chained captures sweeping every PAM4 level over every lane
		rearm();
		run_captures(5, 1'b1, 1'b0, 1'b0);
		dbg_read = 1'b1;
		wait_for_done("after chained captures");
		dbg_read = 1'b0;
		check_stored_frames(40);
		read_rows(0, 39);

		rearm();
		run_captures(8, 1'b0, 1'b1, 1'b0);
		wait_for_done("with the memory full");
		check_stored_frames(63);
		read_rows(0, rows - 1);

		rearm();
		check_stored_frames(0);
		run_captures(1, 1'b0, 1'b0, 1'b1);
		wait_for_done("after re-arm and capture");
		check_stored_frames(8);
		read_rows(0, rows - 1);

		// A read request straight from READY must leave the memory alone
		rearm();
		check_stored_frames(0);
		dbg_read = 1'b1;
		wait_for_done("after a read request from READY");
		dbg_read = 1'b0;
		check_stored_frames(0);
		read_rows(0, rows - 1);

		assert_fails = uut.u_ctrl.u_chk.fail_count;
		$display("Error counts: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, assert_fails);
		if (mismatch_count == 0 && timeout_count == 0 && assert_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+design
design/error_tracker_pkg.sv
design/frame_packer.sv
design/tracker_ctrl.sv
design/capture_sram.sv
design/readout_slicer.sv
design/error_tracker_top.sv
dv/error_tracker_chk.sv
dv/error_tracker_monitor.sv
dv/error_tracker_tb.sv

/* Bender.yml */
package:
  name: error_tracker

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/error_tracker_pkg.sv
      - design/frame_packer.sv
      - design/tracker_ctrl.sv
      - design/capture_sram.sv
      - design/readout_slicer.sv
      - design/error_tracker_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - dv/error_tracker_chk.sv
      - dv/error_tracker_monitor.sv
      - dv/error_tracker_tb.sv
